// File: sources.f
verilog/csr_pkg.sv
verilog/csr_port_if.sv
verilog/csr_readonly_regs.sv
verilog/csr_trap_regs.sv
verilog/csr_access.sv
verilog/csr_unit.sv
testbench/csr_unit_assertions.sv
testbench/csr_unit_tb.sv

// File: testbench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    logic        clk_i;
    logic        rst_i;
    logic        instr_retired_i;
    logic        except_instr_addr_misaligned_i;
    logic        except_illegal_instr_i;
    logic        except_load_addr_misaligned_i;
    logic        except_store_addr_misaligned_i;
    logic        intrpt_external_i;
    logic        intrpt_timer_i;
    logic        intrpt_soft_i;
    logic [31:1] except_pc_i;
    logic [11:0] addr_i;
    logic [31:0] data_i;
    csr_op_e     op_i;
    logic        we_i;
    logic [31:0] data_o;
    logic        trap_caught_o;
    logic [31:0] trap_jump_addr_o;

    logic [11:0] addr_pool [0:16];      // Counters, IDs, trap regs, one unmapped

    csr_unit dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(dut.u_assertions.fail_count) begin
        if (dut.u_assertions.fail_count != 0) begin
            $display("Regression failed");
            $fatal(1, "An assertion on the CSR unit failed");
        end
    end

    // One CSR access, driven on the falling edge
    task automatic access(input logic [11:0] a, input csr_op_e op, input logic [31:0] d,
                          input logic w);
        @(negedge clk_i);
        addr_i = a;
        op_i   = op;
        data_i = d;
        we_i   = w;
    endtask

    // Request vector {ext, timer, soft, store, load, illegal, instr}
    task automatic requests(input logic [6:0] r, input logic [11:0] a);
        @(negedge clk_i);
        {intrpt_external_i, intrpt_timer_i, intrpt_soft_i, except_store_addr_misaligned_i,
         except_load_addr_misaligned_i, except_illegal_instr_i,
         except_instr_addr_misaligned_i} = r;
        except_pc_i = $urandom;
        addr_i      = a;
        we_i        = 1'b0;
    endtask

    // Polls mid-cycle until the trap strobe rises
    task automatic wait_for_trap(input int limit);
        int n;
        n = 0;
        #5;
        while (!trap_caught_o) begin
            if (n == limit) begin
                $display("Regression failed");
                $fatal(1, "Timed out waiting for trap_caught_o to rise");
            end
            @(negedge clk_i);
            #5;
            n++;
        end
    endtask

    initial begin
        int i;
        void'($urandom(85363));
        addr_pool = '{CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH,
                      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MISA,
                      CSR_MSTATUS, CSR_MSTATUSH, CSR_MTVEC, CSR_MIE, CSR_MIP,
                      CSR_MEPC, CSR_MCAUSE, 12'h7C0};
        rst_i                          = 1'b1;
        instr_retired_i                = 1'b0;
        except_instr_addr_misaligned_i = 1'b0;
        except_illegal_instr_i         = 1'b0;
        except_load_addr_misaligned_i  = 1'b0;
        except_store_addr_misaligned_i = 1'b0;
        intrpt_external_i              = 1'b0;
        intrpt_timer_i                 = 1'b0;
        intrpt_soft_i                  = 1'b0;
        except_pc_i                    = '0;
        addr_i                         = '0;
        data_i                         = '0;
        op_i                           = OP_NONE;
        we_i                           = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        for (i = 9; i < 16; i++) access(addr_pool[i], OP_NONE, 32'd0, 1'b0);  // Reset values

        // Directed read-modify-write on mtvec and mie
        access(CSR_MTVEC, OP_RW, 32'h8000_0101, 1'b1);
        access(CSR_MTVEC, OP_RS, 32'h0000_00F2, 1'b1);
        access(CSR_MTVEC, OP_RC, 32'h8000_0001, 1'b1);
        access(CSR_MIE, OP_RW, 32'hFFFF_FFFF, 1'b1);
        access(CSR_MIE, OP_RC, 32'h0000_0080, 1'b1);
        access(CSR_MIE, OP_RS, 32'h0000_0080, 1'b1);

        // Counters and constants, writes included
        repeat (4) access(CSR_CYCLE, OP_RW, $urandom, 1'b1);
        for (i = 0; i < 8; i++) begin
            access(CSR_INSTRET, OP_RS, $urandom, 1'b1);
            instr_retired_i = $urandom % 2;
        end
        for (i = 0; i < 9; i++) access(addr_pool[i], OP_RW, 32'hFFFF_FFFF, 1'b1);
        access(12'h7C0, OP_RW, 32'hFFFF_FFFF, 1'b1);
        access(CSR_MTVEC, OP_NONE, 32'd0, 1'b0);

        // Random op, data and address sequences, no trap requests
        for (i = 0; i < 300; i++) begin
            access(addr_pool[$urandom % 17], csr_op_e'($urandom % 4), $urandom, $urandom % 2);
            instr_retired_i = $urandom % 2;
        end

        // Requests with MIE clear never trap
        access(CSR_MSTATUS, OP_RW, 32'd0, 1'b1);
        access(CSR_MIE, OP_RW, 32'h0000_0888, 1'b1);
        for (i = 0; i < 40; i++) requests($urandom, addr_pool[9 + $urandom % 7]);

        // Timer request held, trap follows once MIE is set
        requests(7'b010_0000, CSR_MIP);
        access(CSR_MSTATUS, OP_RS, 32'h0000_0008, 1'b1);
        wait_for_trap(10);

        // Vectored, then direct mode
        access(CSR_MTVEC, OP_RW, 32'h0000_2001, 1'b1);
        for (i = 0; i < 150; i++) begin
            requests($urandom & (($urandom % 2) ? 7'h7F : 7'h70), addr_pool[9 + $urandom % 7]);
        end
        access(CSR_MTVEC, OP_RW, 32'h0000_3000, 1'b1);
        for (i = 0; i < 100; i++) begin
            if (i % 10 == 0) access(CSR_MIE, OP_RW, $urandom, 1'b1);   // New enable subset
            requests($urandom, addr_pool[9 + $urandom % 7]);
        end

        // Software writes to mip and mepc in the same cycle as a trap
        access(CSR_MIE, OP_RW, 32'h0000_0888, 1'b1);
        requests(7'b100_0000, CSR_MIP);
        op_i   = OP_RW;                 // Clearing write beats the new pending bit
        data_i = 32'd0;
        we_i   = 1'b1;
        requests(7'b000_0010, CSR_MEPC);
        op_i   = OP_RW;                 // Trap beats this write
        data_i = 32'hFFFF_FFFF;
        we_i   = 1'b1;
        requests(7'd0, CSR_MIP);
        requests(7'd0, CSR_MEPC);
        requests(7'd0, CSR_MCAUSE);
        @(negedge clk_i);

        if (dut.u_assertions.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Assertion failures were recorded");
        end
    end

endmodule

// File: testbench/csr_unit_assertions.sv
`timescale 1ns/1ps

// Port-level checks on the CSR unit against a small reference model
module csr_unit_assertions import csr_pkg::*; (
    input logic        clk_i,
    input logic        rst_i,
    input logic        instr_retired_i,
    input logic        except_instr_addr_misaligned_i,
    input logic        except_illegal_instr_i,
    input logic        except_load_addr_misaligned_i,
    input logic        except_store_addr_misaligned_i,
    input logic        intrpt_external_i,
    input logic        intrpt_timer_i,
    input logic        intrpt_soft_i,
    input logic [31:1] except_pc_i,
    input logic [11:0] addr_i,
    input logic [31:0] data_i,
    input csr_op_e     op_i,
    input logic        we_i,
    input logic [31:0] data_o,
    input logic        trap_caught_o,
    input logic [31:0] trap_jump_addr_o
);

    int          fail_count = 0;         // Failed checks so far
    logic        m_status;               // Model of mstatus.MIE
    logic [31:0] m_mtvec, m_mie, m_mip, m_mepc, m_mcause;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic [31:0] model_rd;               // Expected read data
    logic [31:0] wr_value;               // Expected write value
    logic [31:0] gated;                  // Enabled requests, mie bit layout
    logic        exc_any;
    logic        exp_trap;
    logic [3:0]  exp_cause;
    logic [31:0] exp_jump;

    //////////////////////////////////////////////////////////////
    // Expected read data, write value and trap outputs
    always_comb begin
        case (addr_i)
            CSR_CYCLE:     model_rd = m_cycle[31:0];
            CSR_CYCLEH:    model_rd = m_cycle[63:32];
            CSR_INSTRET:   model_rd = m_instret[31:0];
            CSR_INSTRETH:  model_rd = m_instret[63:32];
            CSR_MVENDORID: model_rd = VENDOR_ID;
            CSR_MARCHID:   model_rd = ARCH_ID;
            CSR_MIMPID:    model_rd = IMPL_ID;
            CSR_MHARTID:   model_rd = HART_ID;
            CSR_MISA:      model_rd = MISA_VALUE;
            CSR_MSTATUS:   model_rd = {28'd0, m_status, 3'd0};
            CSR_MTVEC:     model_rd = m_mtvec;
            CSR_MIE:       model_rd = m_mie;
            CSR_MIP:       model_rd = m_mip;
            CSR_MEPC:      model_rd = m_mepc;
            CSR_MCAUSE:    model_rd = m_mcause;
            default:       model_rd = 32'd0;        // mstatush and unmapped
        endcase
        case (op_i)
            OP_RS:   wr_value = model_rd | data_i;
            OP_RC:   wr_value = model_rd & ~data_i;
            default: wr_value = data_i;
        endcase

        exc_any = except_illegal_instr_i | except_instr_addr_misaligned_i
                | except_load_addr_misaligned_i | except_store_addr_misaligned_i;
        gated = {20'd0, intrpt_external_i, 3'd0, intrpt_timer_i, 3'd0, intrpt_soft_i, 3'd0}
              & m_mie & {32{m_status}};
        exp_trap = (m_status & exc_any) | (|gated);

        // Exceptions first, then external, software, timer
        if (except_illegal_instr_i)              exp_cause = CAUSE_ILLEGAL;
        else if (except_instr_addr_misaligned_i) exp_cause = CAUSE_INSTR_MISALIGNED;
        else if (except_load_addr_misaligned_i)  exp_cause = CAUSE_LOAD_MISALIGNED;
        else if (except_store_addr_misaligned_i) exp_cause = CAUSE_STORE_MISALIGNED;
        else if (gated[MEIE_BIT])                exp_cause = CAUSE_EXT_INT;
        else if (gated[MSIE_BIT])                exp_cause = CAUSE_SOFT_INT;
        else                                     exp_cause = CAUSE_TIMER_INT;

        exp_jump = {m_mtvec[31:2], 2'b00};
        if (m_mtvec[1:0] == 2'b01 && exp_trap && !exc_any) begin
            exp_jump = exp_jump + {26'd0, exp_cause, 2'b00};   // Vectored interrupt
        end
    end

    //////////////////////////////////////////////////////////////
    // Model state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            m_status  <= 1'b0;
            m_mtvec   <= 32'd0;
            m_mie     <= 32'd0;
            m_mip     <= 32'd0;
            m_mepc    <= 32'd0;
            m_mcause  <= 32'd0;
            m_cycle   <= 64'd0;
            m_instret <= 64'd0;
        end else begin
            m_cycle <= m_cycle + 64'd1;
            if (instr_retired_i) begin
                m_instret <= m_instret + 64'd1;
            end
            if (we_i && op_i != OP_NONE) begin
                case (addr_i)
                    CSR_MSTATUS: m_status <= wr_value[MIE_BIT];
                    CSR_MTVEC:   m_mtvec  <= wr_value;
                    CSR_MIE:     m_mie    <= wr_value & 32'h0000_0888;
                    CSR_MIP:     m_mip    <= wr_value & 32'h0000_0888;
                    CSR_MEPC:    m_mepc   <= {wr_value[31:1], 1'b0};
                    default: ;                               // Read-only or unmapped
                endcase
            end
            if (!(we_i && op_i != OP_NONE && addr_i == CSR_MIP)) begin
                m_mip <= m_mip | gated;                      // Pending on gated request
            end
            if (exp_trap) begin
                m_mepc   <= {except_pc_i, 1'b0};             // Beats a software write
                m_mcause <= {!exc_any, 27'd0, exp_cause};
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Checks
    csr_read: assert property (@(posedge clk_i) disable iff (rst_i) data_o == model_rd)
        else begin
            $error("CHECK FAILED csr_read addr %h: expected %h actual %h",
                   $sampled(addr_i), $sampled(model_rd), $sampled(data_o));
            fail_count++;
        end

    trap_gate: assert property (@(posedge clk_i) disable iff (rst_i)
        trap_caught_o == exp_trap)
        else begin
            $error("CHECK FAILED trap_gate: expected %b actual %b",
                   $sampled(exp_trap), $sampled(trap_caught_o));
            fail_count++;
        end

    jump_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        trap_jump_addr_o == exp_jump)
        else begin
            $error("CHECK FAILED jump_addr: expected %h actual %h",
                   $sampled(exp_jump), $sampled(trap_jump_addr_o));
            fail_count++;
        end

endmodule

bind csr_unit csr_unit_assertions u_assertions (.*);

// File: verilog/csr_unit.sv
`timescale 1ns/1ps

// Machine-mode CSR unit
module csr_unit import csr_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        instr_retired_i,

    // Exceptions
    input  logic        except_instr_addr_misaligned_i,
    input  logic        except_illegal_instr_i,
    input  logic        except_load_addr_misaligned_i,
    input  logic        except_store_addr_misaligned_i,

    // Interrupts
    input  logic        intrpt_external_i,
    input  logic        intrpt_timer_i,
    input  logic        intrpt_soft_i,

    input  logic [31:1] except_pc_i,

    // CSR access
    input  logic [11:0] addr_i,
    input  logic [31:0] data_i,
    input  csr_op_e     op_i,
    input  logic        we_i,
    output logic [31:0] data_o,

    // Trap outputs to the fetch stage
    output logic        trap_caught_o,
    output logic [31:0] trap_jump_addr_o
);

    csr_port_if ro_port ();            // To counters and IDs
    csr_port_if trap_port ();          // To trap registers

    csr_access u_access (
        .addr_i    (addr_i),
        .data_i    (data_i),
        .op_i      (op_i),
        .we_i      (we_i),
        .data_o    (data_o),
        .ro_port   (ro_port.master),
        .trap_port (trap_port.master)
    );

    csr_readonly_regs u_readonly (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .instr_retired_i (instr_retired_i),
        .port            (ro_port.block)
    );

    csr_trap_regs u_trap (
        .clk_i                          (clk_i),
        .rst_i                          (rst_i),
        .except_instr_addr_misaligned_i (except_instr_addr_misaligned_i),
        .except_illegal_instr_i         (except_illegal_instr_i),
        .except_load_addr_misaligned_i  (except_load_addr_misaligned_i),
        .except_store_addr_misaligned_i (except_store_addr_misaligned_i),
        .intrpt_external_i              (intrpt_external_i),
        .intrpt_timer_i                 (intrpt_timer_i),
        .intrpt_soft_i                  (intrpt_soft_i),
        .except_pc_i                    (except_pc_i),
        .trap_caught_o                  (trap_caught_o),
        .trap_jump_addr_o               (trap_jump_addr_o),
        .port                           (trap_port.block)
    );

endmodule

// File: verilog/csr_access.sv
`timescale 1ns/1ps

// Address fan-out, read select and read-modify-write value
module csr_access import csr_pkg::*; (
    input  logic [11:0] addr_i,
    input  logic [31:0] data_i,
    input  csr_op_e     op_i,
    input  logic        we_i,
    output logic [31:0] data_o,

    csr_port_if.master  ro_port,       // Counters and IDs
    csr_port_if.master  trap_port      // Trap registers
);

    logic [31:0] read_value;           // Old value of the addressed CSR
    logic [31:0] write_value;          // Value after the op
    logic        write_req;            // Real write request

    //////////////////////////////////////////////////////////////
    // Read select
    // Both blocks see the same address, at most one hits
    assign ro_port.addr   = addr_i;
    assign trap_port.addr = addr_i;

    always_comb begin
        if (ro_port.hit) begin
            read_value = ro_port.rdata;
        end else if (trap_port.hit) begin
            read_value = trap_port.rdata;
        end else begin
            read_value = 32'd0;        // Unmapped reads zero
        end
    end

    assign data_o = read_value;

    //////////////////////////////////////////////////////////////
    // Read-modify-write
    always_comb begin
        case (op_i)
            OP_RW:   write_value = data_i;                 // Plain write
            OP_RS:   write_value = read_value | data_i;    // Set bits
            OP_RC:   write_value = read_value & ~data_i;   // Clear bits
            default: write_value = read_value;             // Unchanged
        endcase
    end

    assign ro_port.wdata   = write_value;
    assign trap_port.wdata = write_value;

    //////////////////////////////////////////////////////////////
    // Write strobes
    // Unmapped writes fall through, no block hits
    assign write_req = we_i && (op_i != OP_NONE);

    assign ro_port.we   = write_req && ro_port.hit;
    assign trap_port.we = write_req && trap_port.hit;

endmodule

// File: verilog/csr_trap_regs.sv
`timescale 1ns/1ps

// Machine trap state plus trap detection and vectoring
module csr_trap_regs import csr_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,

    // Exception requests from the pipeline
    input  logic        except_instr_addr_misaligned_i,
    input  logic        except_illegal_instr_i,
    input  logic        except_load_addr_misaligned_i,
    input  logic        except_store_addr_misaligned_i,

    // Interrupt requests
    input  logic        intrpt_external_i,
    input  logic        intrpt_timer_i,
    input  logic        intrpt_soft_i,

    input  logic [31:1] except_pc_i,        // PC of the trapping instruction

    output logic        trap_caught_o,
    output logic [31:0] trap_jump_addr_o,

    csr_port_if.block   port
);

    // Register state
    logic        mstatus_mie;               // Global interrupt enable
    logic [31:0] mtvec;                     // Base in 31:2, mode in 1:0
    logic        mie_msie;
    logic        mie_mtie;
    logic        mie_meie;
    logic        mip_msip;
    logic        mip_mtip;
    logic        mip_meip;
    logic [31:1] mepc;
    logic        mcause_int;                // Interrupt flag, bit 31
    logic [3:0]  mcause_code;

    // Trap logic
    logic        except_any;
    logic [3:0]  except_cause;
    logic [3:0]  intrpt_cause;
    logic        except_caught;
    logic        int_ext;                   // Gated interrupts
    logic        int_timer;
    logic        int_soft;
    logic        intrpt_caught;
    logic        trap_is_int;               // Taken trap is an interrupt
    logic [3:0]  trap_cause;
    logic [31:0] mtvec_base;

    // Write strobes per register
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mie;
    logic wr_mip;
    logic wr_mepc;

    assign wr_mstatus = port.we && (port.addr == CSR_MSTATUS);
    assign wr_mtvec   = port.we && (port.addr == CSR_MTVEC);
    assign wr_mie     = port.we && (port.addr == CSR_MIE);
    assign wr_mip     = port.we && (port.addr == CSR_MIP);
    assign wr_mepc    = port.we && (port.addr == CSR_MEPC);

    ////////////////////////////////////////////////////////////
    // Cause priority and gating
    assign except_any = except_illegal_instr_i | except_instr_addr_misaligned_i
                      | except_load_addr_misaligned_i | except_store_addr_misaligned_i;

    always_comb begin
        except_cause = CAUSE_INSTR_MISALIGNED;
        if (except_illegal_instr_i)              except_cause = CAUSE_ILLEGAL;
        else if (except_instr_addr_misaligned_i) except_cause = CAUSE_INSTR_MISALIGNED;
        else if (except_load_addr_misaligned_i)  except_cause = CAUSE_LOAD_MISALIGNED;
        else if (except_store_addr_misaligned_i) except_cause = CAUSE_STORE_MISALIGNED;
    end

    assign except_caught = mstatus_mie & except_any;    // Needs MIE only

    assign int_ext   = mstatus_mie & mie_meie & intrpt_external_i;
    assign int_timer = mstatus_mie & mie_mtie & intrpt_timer_i;
    assign int_soft  = mstatus_mie & mie_msie & intrpt_soft_i;

    assign intrpt_caught = int_ext | int_timer | int_soft;

    // External first, then software, then timer
    always_comb begin
        intrpt_cause = CAUSE_TIMER_INT;
        if (int_ext)       intrpt_cause = CAUSE_EXT_INT;
        else if (int_soft) intrpt_cause = CAUSE_SOFT_INT;
    end

    assign trap_caught_o = except_caught | intrpt_caught;
    assign trap_is_int   = intrpt_caught & ~except_caught;   // Exceptions win
    assign trap_cause    = except_caught ? except_cause : intrpt_cause;

    ////////////////////////////////////////////////////////////
    // Jump address
    assign mtvec_base = {mtvec[31:2], 2'b00};

    // Vectored only for interrupts, other modes behave as direct
    assign trap_jump_addr_o = (mtvec[1:0] == 2'b01 && trap_is_int) ?
                              mtvec_base + {26'd0, trap_cause, 2'b00} : mtvec_base;

    ////////////////////////////////////////////////////////////
    // mstatus
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_mie <= 1'b0;
        end else if (wr_mstatus) begin
            mstatus_mie <= port.wdata[MIE_BIT];   // No auto clear on trap
        end
    end

    ////////////////////////////////////////////////////////////
    // mtvec
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtvec <= 32'd0;
        end else if (wr_mtvec) begin
            mtvec <= port.wdata;                  // All bits kept
        end
    end

    ////////////////////////////////////////////////////////////
    // mie
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
        end else if (wr_mie) begin
            mie_msie <= port.wdata[MSIE_BIT];
            mie_mtie <= port.wdata[MTIE_BIT];
            mie_meie <= port.wdata[MEIE_BIT];
        end
    end

    ////////////////////////////////////////////////////////////
    // mip
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mip_msip <= 1'b0;
            mip_mtip <= 1'b0;
            mip_meip <= 1'b0;
        end else if (wr_mip) begin
            mip_msip <= port.wdata[MSIE_BIT];     // Software write wins
            mip_mtip <= port.wdata[MTIE_BIT];
            mip_meip <= port.wdata[MEIE_BIT];
        end else begin
            if (int_soft)  mip_msip <= 1'b1;      // Set on gated request
            if (int_timer) mip_mtip <= 1'b1;
            if (int_ext)   mip_meip <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // mepc
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mepc <= 31'd0;
        end else if (trap_caught_o) begin
            mepc <= except_pc_i;                  // Trap beats software
        end else if (wr_mepc) begin
            mepc <= port.wdata[31:1];
        end
    end

    ////////////////////////////////////////////////////////////
    // mcause
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcause_int  <= 1'b0;
            mcause_code <= 4'd0;
        end else if (trap_caught_o) begin
            mcause_int  <= trap_is_int;
            mcause_code <= trap_cause;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read decode
    always_comb begin
        port.hit   = 1'b1;
        port.rdata = 32'd0;
        case (port.addr)
            CSR_MSTATUS:  port.rdata[MIE_BIT] = mstatus_mie;
            CSR_MSTATUSH: port.rdata = 32'd0;                 // Nothing implemented
            CSR_MTVEC:    port.rdata = mtvec;
            CSR_MIE: begin
                port.rdata[MSIE_BIT] = mie_msie;
                port.rdata[MTIE_BIT] = mie_mtie;
                port.rdata[MEIE_BIT] = mie_meie;
            end
            CSR_MIP: begin
                port.rdata[MSIE_BIT] = mip_msip;
                port.rdata[MTIE_BIT] = mip_mtip;
                port.rdata[MEIE_BIT] = mip_meip;
            end
            CSR_MEPC:     port.rdata = {mepc, 1'b0};          // Bit 0 reads zero
            CSR_MCAUSE:   port.rdata = {mcause_int, 27'd0, mcause_code};
            default:      port.hit   = 1'b0;
        endcase
    end

endmodule

// File: verilog/csr_readonly_regs.sv
`timescale 1ns/1ps

// Counters and constant machine info, never written by software
module csr_readonly_regs import csr_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           instr_retired_i,   // One instruction retired this cycle
    csr_port_if.block      port
);

    logic [63:0] cycle_cnt;                    // Free running
    logic [63:0] instret_cnt;                  // Retired instructions

    //////////////////////////////////////////////////////////////
    // Cycle counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cycle_cnt <= 64'd0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;    // Every cycle out of reset
        end
    end

    //////////////////////////////////////////////////////////////
    // Instret counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instret_cnt <= 64'd0;
        end else if (instr_retired_i) begin
            instret_cnt <= instret_cnt + 64'd1;
        end
    end

    //////////////////////////////////////////////////////////////
    // Read decode
    // Writes are dropped, port.we has no effect here
    always_comb begin
        port.hit   = 1'b1;
        port.rdata = 32'd0;
        case (port.addr)
            CSR_CYCLE:     port.rdata = cycle_cnt[31:0];
            CSR_CYCLEH:    port.rdata = cycle_cnt[63:32];
            CSR_INSTRET:   port.rdata = instret_cnt[31:0];
            CSR_INSTRETH:  port.rdata = instret_cnt[63:32];

            CSR_MVENDORID: port.rdata = VENDOR_ID;
            CSR_MARCHID:   port.rdata = ARCH_ID;
            CSR_MIMPID:    port.rdata = IMPL_ID;
            CSR_MHARTID:   port.rdata = HART_ID;

            CSR_MISA:      port.rdata = MISA_VALUE;   // Fixed I and M

            default: begin
                port.hit   = 1'b0;                    // Not ours
                port.rdata = 32'd0;
            end
        endcase
    end

endmodule

// File: verilog/csr_port_if.sv
`timescale 1ns/1ps

// Link between the access logic and one register block
interface csr_port_if;

    logic [11:0] addr;      // CSR address
    logic [31:0] wdata;     // Read-modify-write result
    logic        we;        // Write strobe, only raised on hit
    logic [31:0] rdata;     // Zero when not hit
    logic        hit;       // Address belongs to this block

    // Access side
    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata,
        input  hit
    );

    // Register block side
    modport block (
        input  addr,
        input  wdata,
        input  we,
        output rdata,
        output hit
    );

endinterface

// File: verilog/csr_pkg.sv
package csr_pkg;

    //////////////////////////////////////////////////////////////
    // CSR operation opcodes
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,                         // No access
        OP_RW   = 2'd1,                         // CSRRW
        OP_RS   = 2'd2,                         // CSRRS
        OP_RC   = 2'd3                          // CSRRC
    } csr_op_e;

    //////////////////////////////////////////////////////////////
    // CSR addresses
    localparam logic [11:0] CSR_CYCLE     = 12'hC00;    // User counters
    localparam logic [11:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [11:0] CSR_INSTRET   = 12'hC02;
    localparam logic [11:0] CSR_INSTRETH  = 12'hC82;

    localparam logic [11:0] CSR_MVENDORID = 12'hF11;    // Machine info
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;

    localparam logic [11:0] CSR_MSTATUS   = 12'h300;    // Machine trap setup
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSTATUSH  = 12'h310;

    localparam logic [11:0] CSR_MEPC      = 12'h341;    // Machine trap handling
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MIP       = 12'h344;

    //////////////////////////////////////////////////////////////
    // Trap cause codes
    localparam logic [3:0] CAUSE_INSTR_MISALIGNED = 4'd0;
    localparam logic [3:0] CAUSE_ILLEGAL          = 4'd2;
    localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

    localparam logic [3:0] CAUSE_SOFT_INT         = 4'd3;
    localparam logic [3:0] CAUSE_TIMER_INT        = 4'd7;
    localparam logic [3:0] CAUSE_EXT_INT          = 4'd11;

    //////////////////////////////////////////////////////////////
    // Identification values
    localparam logic [31:0] VENDOR_ID = 32'h0000_0000;    // Non-commercial
    localparam logic [31:0] ARCH_ID   = 32'h0000_0000;
    localparam logic [31:0] IMPL_ID   = 32'h0000_0001;
    localparam logic [31:0] HART_ID   = 32'h0000_0000;    // Single hart

    // MXL=1 (RV32), M at bit 12, I at bit 8
    localparam logic [31:0] MISA_VALUE = 32'h4000_1100;

    //////////////////////////////////////////////////////////////
    // Field positions
    localparam int MIE_BIT  = 3;                // mstatus.MIE
    localparam int MSIE_BIT = 3;                // Software int, mie/mip
    localparam int MTIE_BIT = 7;                // Timer int
    localparam int MEIE_BIT = 11;               // External int

endpackage
